/* tb/cos_sim_golden.mem */
// Word 0: record count. Each record: LENGTH, then LENGTH pairs {b[31:16], a[15:0]},
// then the expected squared cosine, floor(dot^2 * 2^16 / (normA^2 * normB^2))
00000008
// Parallel, a=(1,2) b=(2,4)
00000002
00020001
00040002
00010000
// Orthogonal, a=(1,0) b=(0,1)
00000002
00000001
00010000
00000000
// General, a=(1,2,3) b=(4,5,6), 1024*2^16/1078
00000003
00040001
00050002
00060003
0000F32D
// Zero vector a, b=(3,5)
00000002
00030000
00050000
00000000
// Single pair
00000001
00070003
00010000
// a=(256,1) b=(1,256), 2^34/65537^2
00000002
00010100
01000001
00000003
// Full scale parallel
00000002
FFFFFFFF
FFFFFFFF
00010000
// a=(1,1,1,1) b=(1,1,1,0), 9/12
00000004
00010001
00010001
00010001
00000001
0000C000

/* cos_sim_top.f */
logic/cos_sim_pkg.sv
logic/cos_sim_apb_regs.sv
logic/cos_sim_dot_acc.sv
logic/cos_sim_norm_acc.sv
logic/cos_sim_divider.sv
logic/cos_sim_top.sv
tb/cos_sim_tb.sv

/* Bender.yml */
package:
  name: cos_sim

sources:
  - files:
      - logic/cos_sim_pkg.sv
      - logic/cos_sim_apb_regs.sv
      - logic/cos_sim_dot_acc.sv
      - logic/cos_sim_norm_acc.sv
      - logic/cos_sim_divider.sv
      - logic/cos_sim_top.sv
  - target: test
    files:
      - tb/cos_sim_tb.sv

/* tb/cos_sim_tb.sv */
////////////////////////////////////////
// Cosine similarity engine testbench
// Replays golden vectors over APB,
// checks results, back-pressure, error
// responses and the STATUS register
////////////////////////////////////////

`timescale 1ns/1ps

module cos_sim_tb;

  localparam int FRAC_BITS = 16;
  localparam int MEM_WORDS = 64;
  localparam int MAX_RECS  = 16;
  localparam int LFSR_SEED = 90915;

  logic        CLK;
  logic        RST;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic [31:0] golden [MEM_WORDS];
  int          rec_base [MAX_RECS];
  int          n_rec;
  int          done_count;
  int          timeout_cycles;
  logic [16:0] lfsr;

  cos_sim_top #(
    .FRAC_BITS (FRAC_BITS)
  ) cos_sim_top_i (
    .CLK     (CLK),
    .RST     (RST),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  // 10 ns clock
  always #5 CLK = ~CLK;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // x^17 + x^14 + 1, output bit is the MSB
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "Value check failed");
    end
  endtask

  // 0 to 3 idle cycles, two LFSR bits
  task automatic idle_gap();
    int n;
    n = 0;
    repeat (2) begin
      n    = n * 2 + lfsr[16];
      lfsr = lfsr_next(lfsr);
    end
    repeat (n) @(negedge CLK);
  endtask

  // One APB transfer, sampled mid-cycle once PREADY is high
  task automatic bus_transfer(input logic wr, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    @(negedge CLK);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge CLK);
    penable = 1'b1;
    #1;
    while (!pready) begin
      @(negedge CLK);
      #1;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge CLK);
    psel    = 1'b0;
    penable = 1'b0;
    idle_gap();
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused;
    bus_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic err);
    bus_transfer(1'b0, addr, 32'h0, data, err);
  endtask

  // LENGTH then every pair of one golden record
  task automatic send_vector(input int r, output logic [31:0] expected);
    int          base;
    int          len;
    logic        err;
    base = rec_base[r];
    len  = golden[base];
    apb_write(cos_sim_pkg::ADDR_LENGTH, golden[base], err);
    check_value("pslverr", err, 32'h0);
    for (int i = 0; i < len; i++) begin
      apb_write(cos_sim_pkg::ADDR_DATA, golden[base + 1 + i], err);
      check_value("pslverr", err, 32'h0);
    end
    expected = golden[base + len + 1];
  endtask

  // Poll STATUS bit 0
  task automatic wait_result();
    logic [31:0] status;
    logic        err;
    status = '0;
    while (!status[0]) begin
      apb_read(cos_sim_pkg::ADDR_STATUS, status, err);
      check_value("pslverr", err, 32'h0);
    end
  endtask

  task automatic read_result(input logic [31:0] expected);
    logic [31:0] rdata;
    logic        err;
    apb_read(cos_sim_pkg::ADDR_RESULT, rdata, err);
    check_value("pslverr", err, 32'h0);
    check_value("result", rdata, expected);
    done_count++;
  endtask

  // Nothing in flight, counter up to date
  task automatic check_idle();
    logic [31:0] status;
    logic        err;
    apb_read(cos_sim_pkg::ADDR_STATUS, status, err);
    check_value("pslverr", err, 32'h0);
    check_value("status.done_cnt", status[15:8], done_count % 256);
    check_value("status[1:0]", status[1:0], 32'h0);
  endtask

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  initial begin
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge CLK);
    $display("Watchdog expired after %0d cycles before the tests finished", timeout_cycles);
    $display(">>> FAIL");
    $fatal(1, "Simulation timed out");
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int          base;
    int          total_pairs;
    logic [31:0] rdata;
    logic [31:0] expected;
    logic        err;
    logic [31:0] burst_exp [3];

    CLK            = 1'b0;
    RST            = 1'b1;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    lfsr           = 17'(LFSR_SEED);
    done_count     = 0;
    timeout_cycles = 0;
    total_pairs    = 0;

    // Word 0 is the record count, records follow back to back
    $readmemh("tb/cos_sim_golden.mem", golden);
    n_rec = golden[0];
    if (n_rec < 3 || n_rec > MAX_RECS) begin
      $display("Golden file does not hold a usable number of records");
      $display(">>> FAIL");
      $fatal(1, "Bad golden file");
    end
    base = 1;
    for (int r = 0; r < n_rec; r++) begin
      rec_base[r] = base;
      total_pairs += golden[base];
      base += golden[base] + 2;
    end
    // Burst replays the first three records
    for (int r = 0; r < 3; r++) begin
      total_pairs += golden[rec_base[r]];
    end
    timeout_cycles = (total_pairs + (n_rec + 3) * (FRAC_BITS + 10)) * 4 + 1000;

    repeat (5) @(negedge CLK);
    RST = 1'b0;

    // Access errors on an idle engine
    apb_read(cos_sim_pkg::ADDR_RESULT, rdata, err);
    check_value("pslverr", err, 32'h1);
    check_value("prdata", rdata, 32'h0);
    apb_write(cos_sim_pkg::ADDR_STATUS, 32'h0000_0003, err);
    check_value("pslverr", err, 32'h1);
    apb_read(cos_sim_pkg::ADDR_DATA, rdata, err);
    check_value("pslverr", err, 32'h1);
    check_value("prdata", rdata, 32'h0);
    apb_write(cos_sim_pkg::ADDR_RESULT, 32'h1234_5678, err);
    check_value("pslverr", err, 32'h1);
    apb_read(8'h10, rdata, err);
    check_value("pslverr", err, 32'h1);
    // LENGTH comes out of reset as 1
    apb_read(cos_sim_pkg::ADDR_LENGTH, rdata, err);
    check_value("pslverr", err, 32'h0);
    check_value("length", rdata, 32'h1);
    check_idle();

    // One vector at a time
    for (int r = 0; r < n_rec; r++) begin
      send_vector(r, expected);
      wait_result();
      read_result(expected);
      check_idle();
    end

    // Three vectors in flight, no reads in between
    for (int r = 0; r < 3; r++) begin
      send_vector(r, burst_exp[r]);
    end
    apb_read(cos_sim_pkg::ADDR_STATUS, rdata, err);
    check_value("status.busy", rdata[1], 32'h1);
    for (int r = 0; r < 3; r++) begin
      wait_result();
      read_result(burst_exp[r]);
    end
    check_idle();

    $display(">>> PASS");
    $finish;
  end

endmodule

/* logic/cos_sim_top.sv */
////////////////////////////////////////
// Cosine similarity engine top level
// APB register block feeding the dot
// and norm accumulators and the
// squared cosine divider
////////////////////////////////////////

`timescale 1ns/1ps

module cos_sim_top #(
  parameter int FRAC_BITS = 16
) (
  input  logic                                   CLK,
  input  logic                                   RST,
  input  logic                                   psel,
  input  logic                                   penable,
  input  logic                                   pwrite,
  input  logic [cos_sim_pkg::APB_ADDR_WIDTH-1:0] paddr,
  input  logic [31:0]                            pwdata,
  output logic [31:0]                            prdata,
  output logic                                   pready,
  output logic                                   pslverr
);

  cos_sim_pkg::elem_pair_t elem;
  cos_sim_pkg::acc_sums_t  sums;
  logic [cos_sim_pkg::ACC_WIDTH-1:0] dot_sum;
  logic [cos_sim_pkg::ACC_WIDTH-1:0] norm_a_sum;
  logic [cos_sim_pkg::ACC_WIDTH-1:0] norm_b_sum;
  logic        sums_valid;
  logic        take;
  logic        pop;
  logic [31:0] result;
  logic        result_valid;
  logic        busy_div;

  ////////////////////////////////////////
  // Register block
  ////////////////////////////////////////

  cos_sim_apb_regs cos_sim_apb_regs_i (
    .CLK          (CLK),
    .RST          (RST),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .sums_valid   (sums_valid),
    .result_valid (result_valid),
    .result       (result),
    .busy_div     (busy_div),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .elem         (elem),
    .pop          (pop)
  );

  ////////////////////////////////////////
  // Accumulators
  ////////////////////////////////////////

  // Dot accumulator flag stands for both
  cos_sim_dot_acc cos_sim_dot_acc_i (
    .CLK        (CLK),
    .RST        (RST),
    .elem       (elem),
    .take       (take),
    .dot_sum    (dot_sum),
    .sums_valid (sums_valid)
  );

  cos_sim_norm_acc cos_sim_norm_acc_i (
    .CLK        (CLK),
    .RST        (RST),
    .elem       (elem),
    .take       (take),
    .norm_a_sum (norm_a_sum),
    .norm_b_sum (norm_b_sum)
  );

  assign sums = cos_sim_pkg::acc_sums_t'{
    dot:    dot_sum,
    norm_a: norm_a_sum,
    norm_b: norm_b_sum
  };

  ////////////////////////////////////////
  // Divider
  ////////////////////////////////////////

  cos_sim_divider #(
    .FRAC_BITS (FRAC_BITS)
  ) cos_sim_divider_i (
    .CLK          (CLK),
    .RST          (RST),
    .sums         (sums),
    .sums_valid   (sums_valid),
    .pop          (pop),
    .take         (take),
    .result       (result),
    .result_valid (result_valid),
    .busy         (busy_div)
  );

endmodule

/* logic/cos_sim_divider.sv */
////////////////////////////////////////
// Squared cosine divider
// dot^2 * 2^FRAC_BITS / (na^2 * nb^2)
// by restoring shift-subtract, one
// quotient bit per cycle
////////////////////////////////////////

`timescale 1ns/1ps

module cos_sim_divider #(
  parameter int FRAC_BITS = 16
) (
  input  logic                   CLK,
  input  logic                   RST,
  input  cos_sim_pkg::acc_sums_t sums,
  input  logic                   sums_valid,
  input  logic                   pop,
  output logic                   take,
  output logic [31:0]            result,
  output logic                   result_valid,
  output logic                   busy
);

  // Product and dividend widths
  localparam int PROD_W = 2 * cos_sim_pkg::ACC_WIDTH;
  localparam int DVD_W  = PROD_W + FRAC_BITS;
  // Quotient never exceeds 2^FRAC_BITS
  localparam int QUO_W  = FRAC_BITS + 1;
  localparam int CNT_W  = $clog2(FRAC_BITS + 2);

  cos_sim_pkg::div_state_e state;
  logic [PROD_W-1:0] dot_sq;
  logic [PROD_W-1:0] norm_prod;
  logic [DVD_W-1:0]  rem;
  logic [DVD_W-1:0]  div_sh;
  logic [DVD_W-1:0]  diff;
  logic              fits;
  logic [QUO_W-1:0]  quot;
  logic [CNT_W-1:0]  step;
  logic              zero_div;

  ////////////////////////////////////////
  // Operands
  ////////////////////////////////////////

  // Sums stay stable through the LOAD cycle
  assign dot_sq    = sums.dot * sums.dot;
  assign norm_prod = sums.norm_a * sums.norm_b;

  // Trial subtraction
  assign fits = (rem >= div_sh);
  assign diff = rem - div_sh;

  assign take = (state == cos_sim_pkg::LOAD);
  assign busy = (state != cos_sim_pkg::IDLE);

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= cos_sim_pkg::IDLE;
      step         <= '0;
      result_valid <= 1'b0;
    end else begin
      // Host read frees the output register
      if (pop) begin
        result_valid <= 1'b0;
      end
      case (state)
        cos_sim_pkg::IDLE: begin
          if (sums_valid) begin
            state <= cos_sim_pkg::LOAD;
          end
        end
        cos_sim_pkg::LOAD: begin
          step  <= '0;
          state <= cos_sim_pkg::ITER;
        end
        cos_sim_pkg::ITER: begin
          // FRAC_BITS+1 steps, MSB first
          step <= step + 1'b1;
          if (step == CNT_W'(FRAC_BITS)) begin
            state <= cos_sim_pkg::HOLD;
          end
        end
        cos_sim_pkg::HOLD: begin
          // Wait here while the previous result is unread
          if (!result_valid) begin
            result_valid <= 1'b1;
            state        <= cos_sim_pkg::IDLE;
          end
        end
        default: begin
          state <= cos_sim_pkg::IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      cos_sim_pkg::LOAD: begin
        // Divisor starts aligned to the top quotient bit
        rem      <= DVD_W'(dot_sq) << FRAC_BITS;
        div_sh   <= DVD_W'(norm_prod) << FRAC_BITS;
        quot     <= '0;
        zero_div <= (norm_prod == '0);
      end
      cos_sim_pkg::ITER: begin
        if (fits) begin
          rem <= diff;
        end
        div_sh <= div_sh >> 1;
        quot   <= {quot[QUO_W-2:0], fits};
      end
      cos_sim_pkg::HOLD: begin
        // Zero vector gives zero similarity
        if (!result_valid) begin
          result <= zero_div ? '0 : 32'(quot);
        end
      end
      default: begin
      end
    endcase
  end

endmodule

/* logic/cos_sim_norm_acc.sv */
////////////////////////////////////////
// Squared norm accumulator
// Sums a*a and b*b over one vector in
// step with the dot accumulator
////////////////////////////////////////

`timescale 1ns/1ps

module cos_sim_norm_acc (
  input  logic                              CLK,
  input  logic                              RST,
  input  cos_sim_pkg::elem_pair_t           elem,
  input  logic                              take,
  output logic [cos_sim_pkg::ACC_WIDTH-1:0] norm_a_sum,
  output logic [cos_sim_pkg::ACC_WIDTH-1:0] norm_b_sum
);

  logic [2*cos_sim_pkg::DATA_WIDTH-1:0] sq_a;
  logic [2*cos_sim_pkg::DATA_WIDTH-1:0] sq_b;
  logic [cos_sim_pkg::ACC_WIDTH-1:0] run_a;
  logic [cos_sim_pkg::ACC_WIDTH-1:0] run_b;
  logic [cos_sim_pkg::ACC_WIDTH-1:0] next_a;
  logic [cos_sim_pkg::ACC_WIDTH-1:0] next_b;

  // Element squares
  assign sq_a = elem.a * elem.a;
  assign sq_b = elem.b * elem.b;

  assign next_a = run_a + cos_sim_pkg::ACC_WIDTH'(sq_a);
  assign next_b = run_b + cos_sim_pkg::ACC_WIDTH'(sq_b);

  // Running sums, cleared after the last pair
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      run_a <= '0;
      run_b <= '0;
    end else if (elem.valid) begin
      run_a <= elem.last ? '0 : next_a;
      run_b <= elem.last ? '0 : next_b;
    end
  end

  // Hold registers
  // Filled and emptied on the same cycles as the dot hold register
  always_ff @(posedge CLK) begin
    if (elem.valid && elem.last) begin
      norm_a_sum <= next_a;
      norm_b_sum <= next_b;
    end else if (take) begin
      norm_a_sum <= '0;
      norm_b_sum <= '0;
    end
  end

endmodule

/* logic/cos_sim_dot_acc.sv */
////////////////////////////////////////
// Dot product accumulator
// Sums a*b over one vector and holds
// the result until the divider takes it
////////////////////////////////////////

`timescale 1ns/1ps

module cos_sim_dot_acc (
  input  logic                              CLK,
  input  logic                              RST,
  input  cos_sim_pkg::elem_pair_t           elem,
  input  logic                              take,
  output logic [cos_sim_pkg::ACC_WIDTH-1:0] dot_sum,
  output logic                              sums_valid
);

  logic [2*cos_sim_pkg::DATA_WIDTH-1:0] prod;
  logic [cos_sim_pkg::ACC_WIDTH-1:0] run_sum;
  logic [cos_sim_pkg::ACC_WIDTH-1:0] next_sum;

  // Element product
  assign prod     = elem.a * elem.b;
  assign next_sum = run_sum + cos_sim_pkg::ACC_WIDTH'(prod);

  // Running sum and valid flag
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      run_sum    <= '0;
      sums_valid <= 1'b0;
    end else begin
      if (elem.valid) begin
        // Restart for the next vector on the last pair
        run_sum <= elem.last ? '0 : next_sum;
      end
      // Next vector's pairs may arrive in the take cycle
      if (elem.valid && elem.last) begin
        sums_valid <= 1'b1;
      end else if (take) begin
        sums_valid <= 1'b0;
      end
    end
  end

  // Hold register
  always_ff @(posedge CLK) begin
    if (elem.valid && elem.last) begin
      dot_sum <= next_sum;
    end else if (take) begin
      // Empty after hand-off
      dot_sum <= '0;
    end
  end

endmodule

/* logic/cos_sim_apb_regs.sv */
////////////////////////////////////////
// Cosine similarity APB register block
// LENGTH, DATA, RESULT and STATUS
// registers, pair sequencing and
// PREADY back-pressure on last pairs
////////////////////////////////////////

`timescale 1ns/1ps

module cos_sim_apb_regs (
  input  logic                                   CLK,
  input  logic                                   RST,
  input  logic                                   psel,
  input  logic                                   penable,
  input  logic                                   pwrite,
  input  logic [cos_sim_pkg::APB_ADDR_WIDTH-1:0] paddr,
  input  logic [31:0]                            pwdata,
  input  logic                                   sums_valid,
  input  logic                                   result_valid,
  input  logic [31:0]                            result,
  input  logic                                   busy_div,
  output logic [31:0]                            prdata,
  output logic                                   pready,
  output logic                                   pslverr,
  output cos_sim_pkg::elem_pair_t                elem,
  output logic                                   pop
);

  logic access;
  logic is_length;
  logic is_data;
  logic is_result;
  logic is_status;
  logic acc_err;
  logic stall;
  logic last_pair;
  logic [cos_sim_pkg::LEN_WIDTH-1:0] length_q;
  logic [cos_sim_pkg::LEN_WIDTH-1:0] last_idx;
  logic [cos_sim_pkg::LEN_WIDTH-1:0] pair_cnt;
  logic [7:0] done_cnt;
  logic result_valid_q;
  cos_sim_pkg::status_t status;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // Access phase of any transfer
  assign access    = psel & penable;
  assign is_length = (paddr == cos_sim_pkg::ADDR_LENGTH);
  assign is_data   = (paddr == cos_sim_pkg::ADDR_DATA);
  assign is_result = (paddr == cos_sim_pkg::ADDR_RESULT);
  assign is_status = (paddr == cos_sim_pkg::ADDR_STATUS);

  // Error per register, unmapped always fails
  always_comb begin
    if (is_length) begin
      acc_err = 1'b0;
    end else if (is_data) begin
      acc_err = ~pwrite;
    end else if (is_result) begin
      acc_err = pwrite | ~result_valid;
    end else if (is_status) begin
      acc_err = pwrite;
    end else begin
      acc_err = 1'b1;
    end
  end

  // Zero length behaves as one
  assign last_idx  = (length_q == '0) ? '0 : length_q - 1'b1;
  assign last_pair = (pair_cnt == last_idx);

  // Last pair must wait until the divider took the previous sums
  assign stall   = access & pwrite & is_data & last_pair & sums_valid;
  assign pready  = access & ~stall;
  assign pslverr = pready & acc_err;

  ////////////////////////////////////////
  // Element and pop strobes
  ////////////////////////////////////////

  assign elem.valid = access & pwrite & is_data & ~stall;
  assign elem.last  = last_pair;
  assign elem.a     = pwdata[cos_sim_pkg::DATA_WIDTH-1:0];
  assign elem.b     = pwdata[2*cos_sim_pkg::DATA_WIDTH-1:cos_sim_pkg::DATA_WIDTH];

  // Successful RESULT read
  assign pop = access & ~pwrite & is_result & result_valid;

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////

  // Busy while a vector is partly in, pending or dividing
  assign status.reserved_hi  = '0;
  assign status.done_cnt     = done_cnt;
  assign status.reserved_lo  = '0;
  assign status.busy         = busy_div | sums_valid | (pair_cnt != '0);
  assign status.result_valid = result_valid;

  // Erroneous reads return zero
  always_comb begin
    prdata = '0;
    if (access && !pwrite && !acc_err) begin
      if (is_length) begin
        prdata = 32'(length_q);
      end else if (is_result) begin
        prdata = result;
      end else if (is_status) begin
        prdata = status;
      end
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      length_q       <= cos_sim_pkg::LEN_WIDTH'(1);
      pair_cnt       <= '0;
      done_cnt       <= '0;
      result_valid_q <= 1'b0;
    end else begin
      // Count each new result once, wraps at 256
      result_valid_q <= result_valid;
      if (result_valid && !result_valid_q) begin
        done_cnt <= done_cnt + 1'b1;
      end
      // New length restarts the pair count
      if (access && pwrite && is_length) begin
        length_q <= pwdata[cos_sim_pkg::LEN_WIDTH-1:0];
        pair_cnt <= '0;
      end else if (elem.valid) begin
        pair_cnt <= last_pair ? '0 : pair_cnt + 1'b1;
      end
    end
  end

endmodule

/* logic/cos_sim_pkg.sv */
////////////////////////////////////////
// Cosine similarity engine package
// Element and accumulator widths,
// APB register map, divider states and
// the structs passed between blocks
////////////////////////////////////////

package cos_sim_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Unsigned element width
  localparam int DATA_WIDTH = 16;
  // Vector length field, 0 counts as 1
  localparam int LEN_WIDTH = 8;
  // Product width plus length bits so a full vector never overflows
  localparam int ACC_WIDTH = 2 * DATA_WIDTH + LEN_WIDTH;
  localparam int APB_ADDR_WIDTH = 8;

  ////////////////////////////////////////
  // Enums
  ////////////////////////////////////////

  // APB register map
  typedef enum logic [APB_ADDR_WIDTH-1:0] {
    ADDR_LENGTH = 8'h00,
    ADDR_DATA   = 8'h04,
    ADDR_RESULT = 8'h08,
    ADDR_STATUS = 8'h0C
  } reg_addr_e;

  // Divider FSM
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    ITER,
    HOLD
  } div_state_e;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // One element pair from the register block
  typedef struct packed {
    logic                  valid;
    logic                  last;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
  } elem_pair_t;

  // Finished sums of one vector
  typedef struct packed {
    logic [ACC_WIDTH-1:0] dot;
    logic [ACC_WIDTH-1:0] norm_a;
    logic [ACC_WIDTH-1:0] norm_b;
  } acc_sums_t;

  // STATUS register layout
  typedef struct packed {
    logic [15:0] reserved_hi;
    logic [7:0]  done_cnt;
    logic [5:0]  reserved_lo;
    logic        busy;
    logic        result_valid;
  } status_t;

endpackage
